/* block_writer/block_writer.sv */
/*
 * Writes one 2x2 block of the padded output as four single-beat writes, TL TR BL BR.
 * Expects the window of the current centre to stay valid for the whole block.
 */
`include "pad_dma_defines.svh"

module block_writer (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    write_start_i,
    input  pad_dma_pkg::addr_t      dst_base_i,
    input  pad_dma_pkg::dim_t       width_i,
    input  pad_dma_pkg::dim_t       block_row_i,
    input  pad_dma_pkg::dim_t       block_col_i,
    input  pad_dma_pkg::ctr_t       center_row_i,
    input  pad_dma_pkg::ctr_t       center_col_i,
    input  pad_dma_pkg::window_t    window_i,
    input  logic                    awready_i,
    input  logic                    wready_i,
    input  logic                    bvalid_i,
    output pad_dma_pkg::addr_t      awaddr_o,
    output logic                    awvalid_o,
    output pad_dma_pkg::word_t      wdata_o,
    output logic                    wlast_o,
    output logic                    wvalid_o,
    output logic                    bready_o,
    output logic                    write_done_o
);
    logic [1:0]         slot;      // Word in flight, bit 1 row, bit 0 column
    logic [1:0]         sel;       // Word being loaded
    logic               load;
    logic               b_hs;
    pad_dma_pkg::dim_t  out_r;
    pad_dma_pkg::dim_t  out_c;
    pad_dma_pkg::dim_t  src_r;
    pad_dma_pkg::dim_t  src_c;
    pad_dma_pkg::dim_t  edge_hi;
    pad_dma_pkg::ctr_t  rel_r;
    pad_dma_pkg::ctr_t  rel_c;
    pad_dma_pkg::ctr_t  ri;
    pad_dma_pkg::ctr_t  ci;
    logic [3:0]         win_idx;
    pad_dma_pkg::addr_t aw_next;

    assign b_hs = bvalid_i & bready_o;
    assign sel  = write_start_i ? 2'd0 : slot + 2'd1;
    assign load = write_start_i || (b_hs && slot != 2'd3);

    assign out_r   = block_row_i + pad_dma_pkg::dim_t'(sel[1]);
    assign out_c   = block_col_i + pad_dma_pkg::dim_t'(sel[0]);
    assign edge_hi = width_i + 1'b1;   // Last padded index

    // Mirror rule on the 1-based source grid
    always_comb begin
        src_r = out_r;
        src_c = out_c;
        if (out_r == '0) src_r = 6'd2;
        else if (out_r == edge_hi) src_r = width_i - 1'b1;
        if (out_c == '0) src_c = 6'd2;
        else if (out_c == edge_hi) src_c = width_i - 1'b1;
    end

    assign rel_r   = pad_dma_pkg::ctr_t'({1'b0, src_r}) - center_row_i;
    assign rel_c   = pad_dma_pkg::ctr_t'({1'b0, src_c}) - center_col_i;
    assign ri      = rel_r + pad_dma_pkg::ctr_t'(1);
    assign ci      = rel_c + pad_dma_pkg::ctr_t'(1);
    assign win_idx = 4'd3 * {2'b00, ri[1:0]} + {2'b00, ci[1:0]};

    assign aw_next = dst_base_i + ((pad_dma_pkg::addr_t'(out_r)
                     * (pad_dma_pkg::addr_t'(width_i) + 2)
                     + pad_dma_pkg::addr_t'(out_c)) << 2);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            slot         <= '0;
            awvalid_o    <= 1'b0;
            wvalid_o     <= 1'b0;
            wlast_o      <= 1'b0;
            bready_o     <= 1'b0;
            write_done_o <= 1'b0;
        end else begin
            write_done_o <= 1'b0;
            if (load) begin
                slot      <= sel;
                awvalid_o <= 1'b1;
            end
            if (awvalid_o && awready_i) begin
                awvalid_o <= 1'b0;
                wvalid_o  <= 1'b1;
                wlast_o   <= 1'b1;   // Every burst is one beat
                bready_o  <= 1'b1;
            end
            if (wvalid_o && wready_i) begin
                wvalid_o <= 1'b0;
                wlast_o  <= 1'b0;
            end
            if (b_hs) begin
                bready_o <= 1'b0;
                if (slot == 2'd3) write_done_o <= 1'b1;
            end
        end
    end

    // Data is picked with the address, W just replays it after AW
    always_ff @(posedge clk) begin
        if (load) begin
            awaddr_o <= aw_next;
            wdata_o  <= window_i[win_idx*`PAD_DMA_DATA_W +: `PAD_DMA_DATA_W];
        end
    end

    a_aw_w_apart: assert property (@(posedge clk) disable iff (!rst_n)
        !(awvalid_o && wvalid_o));

    // Sequencer centre placement keeps every mirrored source inside the window
    a_offset_range: assert property (@(posedge clk) disable iff (!rst_n)
        load |-> (rel_r >= -1 && rel_r <= 1 && rel_c >= -1 && rel_c <= 1));

endmodule

/* common/pad_dma_defines.svh */
/*
 * Sizes shared by the mirror-padding DMA engine.
 * DIM_W bounds the matrix width to 62 (even values, 4 and up).
 */
`ifndef PAD_DMA_DEFINES_SVH
`define PAD_DMA_DEFINES_SVH

// Matrix word and byte address
`define PAD_DMA_DATA_W 32
`define PAD_DMA_ADDR_W 32

// Width field and block coordinates
`define PAD_DMA_DIM_W 6

// Signed 1-based centre coordinate, one bit wider than DIM_W
`define PAD_DMA_CTR_W 7

`define PAD_DMA_WIN_N 9   // 3x3 window

`endif

/* common/pad_dma_pkg.sv */
/*
 * Types of the mirror-padding DMA engine.
 * Window words are packed row-major, word 0 at (centre-1, centre-1).
 */
`include "pad_dma_defines.svh"

package pad_dma_pkg;

    typedef logic [`PAD_DMA_DATA_W-1:0] word_t;
    typedef logic [`PAD_DMA_ADDR_W-1:0] addr_t;

    // Matrix width or 0-based output block coordinate
    typedef logic [`PAD_DMA_DIM_W-1:0] dim_t;

    // 1-based source coordinate, signed so a neighbour of row 1 stays ordered
    typedef logic signed [`PAD_DMA_CTR_W-1:0] ctr_t;

    typedef logic [`PAD_DMA_WIN_N*`PAD_DMA_DATA_W-1:0] window_t;

    typedef enum logic [1:0] {
        seq_idle,     // Waiting for start, done high
        seq_fetch,    // Window read in progress
        seq_write,    // Block write in progress
        seq_finish    // Done high, waiting for start to drop
    } seq_state_t;

endpackage

/* pad_dma_top.f */
+incdir+common
common/pad_dma_pkg.sv
verilog/block_sequencer.sv
window_fetch/window_fetch.sv
block_writer/block_writer.sv
verilog/pad_dma_top.sv
test/pad_dma_checker.sv
test/tb_pad_dma.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the padding DMA testbench with Verilator, runs it, and checks the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_pad_dma \
    -f pad_dma_top.f --Mdir obj_dir -o tb_pad_dma \
    && ./obj_dir/tb_pad_dma | tee sim.log \
    && grep -qx "TEST OK" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation did not pass"; exit 1; }

/* test/pad_dma_checker.sv */
/*
 * Checks every read and write of the padding DMA against the mirror rule.
 * Expected data is source address XOR key; config inputs hold for a whole run.
 */
module pad_dma_checker (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                start_i,
    input  logic                done_i,
    input  pad_dma_pkg::addr_t  src_base_i,
    input  pad_dma_pkg::addr_t  dst_base_i,
    input  pad_dma_pkg::dim_t   width_i,
    input  pad_dma_pkg::word_t  key_i,
    input  pad_dma_pkg::addr_t  araddr_i,
    input  logic                arvalid_i,
    input  logic                arready_i,
    input  pad_dma_pkg::addr_t  awaddr_i,
    input  logic                awvalid_i,
    input  logic                awready_i,
    input  pad_dma_pkg::word_t  wdata_i,
    input  logic                wlast_i,
    input  logic                wvalid_i,
    input  logic                wready_i,
    output int                  err_cnt_o,
    output int                  run_cnt_o
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [4095:0]      seen;       // One bit per padded output word
    pad_dma_pkg::addr_t aw_q;
    logic               done_q;
    logic               start_q;
    logic               out_of_reset;
    int                 wr_cnt;
    int                 rd_cnt;
    int                 run_err;

    // Output index to 1-based source index
    function automatic int unsigned mirror_idx(input int unsigned k, input int unsigned w);
        if (k == 0) return 2;
        if (k == w + 1) return w - 1;
        return k;
    endfunction

    task automatic flag_error();
        err_cnt_o++;
        run_err++;
    endtask

    task automatic check_write(input pad_dma_pkg::addr_t addr, input pad_dma_pkg::word_t data);
        int unsigned        w;
        int unsigned        pw;
        int unsigned        off;
        int unsigned        sr;
        int unsigned        sc;
        pad_dma_pkg::word_t exp;
        w   = width_i;
        pw  = w + 2;
        off = (addr - dst_base_i) >> 2;
        wr_cnt++;
        if (addr < dst_base_i || addr[1:0] != 2'b00 || off >= pw * pw) begin
            $display("Write at 0x%08h lies outside the destination matrix", addr);
            flag_error();
        end else begin
            if (seen[off]) begin
                $display("Output word at 0x%08h was written more than once", addr);
                flag_error();
            end
            seen[off] = 1'b1;
            sr  = mirror_idx(off / pw, w);
            sc  = mirror_idx(off % pw, w);
            exp = (src_base_i + 32'(((sr - 1) * w + (sc - 1)) * 4)) ^ key_i;
            if (data !== exp) begin
                $display("error wdata_o at 0x%08h: got 0x%08h, expected 0x%08h", addr, data, exp);
                flag_error();
            end
        end
    endtask

    always @(posedge clk) begin
        int unsigned pw;
        int unsigned src_bytes;
        if (!rst_n) begin
            seen         = '0;
            aw_q         = '0;
            done_q       = 1'b1;
            start_q      = 1'b0;
            out_of_reset = 1'b0;
            wr_cnt       = 0;
            rd_cnt       = 0;
            run_err      = 0;
            err_cnt_o    = 0;
            run_cnt_o    = 0;
        end else begin
            pw        = 32'(width_i) + 2;
            src_bytes = 32'(width_i) * 32'(width_i) * 4;
            if (!out_of_reset && !done_i) begin
                $display("done_o is low right after reset");
                flag_error();
            end
            if (done_q && !done_i) begin   // Run begins
                if (!start_q) begin
                    $display("done_o fell without a start");
                    flag_error();
                end
                seen    = '0;
                wr_cnt  = 0;
                rd_cnt  = 0;
                run_err = 0;
            end
            if (arvalid_i && arready_i) begin
                rd_cnt++;
                if (araddr_i < src_base_i || araddr_i - src_base_i >= src_bytes
                    || araddr_i[1:0] != 2'b00) begin
                    $display("Read at 0x%08h lies outside the source matrix", araddr_i);
                    flag_error();
                end
            end
            if (awvalid_i && awready_i) aw_q = awaddr_i;
            if (wvalid_i && wready_i) begin
                if (wlast_i !== 1'b1) begin
                    $display("error wlast_o at 0x%08h: got 0x%0h, expected 0x1",
                             aw_q, wlast_i);
                    flag_error();
                end
                check_write(aw_q, wdata_i);
            end
            if (!done_q && done_i) begin
                run_cnt_o++;
                if (wr_cnt != int'(pw * pw)) begin
                    $display("Run made %0d writes instead of %0d", wr_cnt, pw * pw);
                    flag_error();
                end
                if (rd_cnt != int'(9 * (pw / 2) * (pw / 2))) begin
                    $display("Run made %0d reads instead of %0d",
                             rd_cnt, 9 * (pw / 2) * (pw / 2));
                    flag_error();
                end
                $display("Run %0d, width %0d: %0d writes, %0d reads, %0d errors",
                         run_cnt_o, width_i, wr_cnt, rd_cnt, run_err);
            end
            done_q       = done_i;
            start_q      = start_i;
            out_of_reset = 1'b1;
        end
    end

endmodule

/* test/tb_pad_dma.sv */
/*
 * Testbench for the mirror-padding DMA with an AXI memory that reads back address XOR key.
 * Rows with stalls delay every ready and response valid by 0 to 3 random cycles.
 */
module tb_pad_dma;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int n_rows      = 6;
    localparam int start_limit = 20;   // Cycles for done_o to fall after start

    typedef struct packed {
        logic [31:0] src;
        logic [31:0] dst;
        logic [5:0]  width;
        logic [31:0] key;
        logic        stall;
    } row_t;

    // Source base, destination base, width, data key, stall enable
    row_t table_rows [n_rows] = '{
        '{32'h0000_1000, 32'h0000_8000, 6'd4,  32'ha5a5_0000, 1'b0},
        '{32'h0000_1000, 32'h0000_8000, 6'd4,  32'ha5a5_0000, 1'b1},
        '{32'h0002_0000, 32'h0003_0000, 6'd8,  32'h1357_9bdf, 1'b0},
        '{32'h0010_0000, 32'h0020_0000, 6'd62, 32'hdead_beef, 1'b0},
        '{32'h0002_0000, 32'h0003_0000, 6'd8,  32'h1357_9bdf, 1'b1},
        '{32'h4000_0010, 32'h5000_0040, 6'd6,  32'h0000_0000, 1'b1}
    };

    logic               clk = 1'b0;
    logic               rst_n;
    logic               start;
    logic               done;
    logic               stall_en;
    logic               hung;
    pad_dma_pkg::addr_t src_addr;
    pad_dma_pkg::addr_t dst_addr;
    pad_dma_pkg::dim_t  width;
    pad_dma_pkg::word_t key;
    pad_dma_pkg::addr_t araddr;
    pad_dma_pkg::addr_t awaddr;
    pad_dma_pkg::word_t rdata = '0;
    pad_dma_pkg::word_t wdata;
    logic               arvalid;
    logic               arready = 1'b0;
    logic               rvalid  = 1'b0;
    logic               rready;
    logic               awvalid;
    logic               awready = 1'b0;
    logic               wvalid;
    logic               wready  = 1'b0;
    logic               wlast;
    logic               bvalid  = 1'b0;
    logic               bready;
    logic               rd_data_phase;
    logic [1:0]         wr_phase;      // 0 address, 1 data, 2 response
    logic [1:0]         rd_wait;
    logic [1:0]         wr_wait;
    int                 errs;
    int                 runs;

    always #20 clk = ~clk;

    pad_dma_top uut (
        .clk(clk), .rst_n(rst_n),
        .src_addr_i(src_addr), .dst_addr_i(dst_addr), .mat_width_i(width),
        .start_i(start), .done_o(done),
        .araddr_o(araddr), .arvalid_o(arvalid), .arready_i(arready),
        .rdata_i(rdata), .rvalid_i(rvalid), .rready_o(rready),
        .awaddr_o(awaddr), .awvalid_o(awvalid), .awready_i(awready),
        .wdata_o(wdata), .wlast_o(wlast), .wvalid_o(wvalid), .wready_i(wready),
        .bvalid_i(bvalid), .bready_o(bready)
    );

    pad_dma_checker chk (
        .clk(clk), .rst_n(rst_n), .start_i(start), .done_i(done),
        .src_base_i(src_addr), .dst_base_i(dst_addr), .width_i(width), .key_i(key),
        .araddr_i(araddr), .arvalid_i(arvalid), .arready_i(arready),
        .awaddr_i(awaddr), .awvalid_i(awvalid), .awready_i(awready),
        .wdata_i(wdata), .wlast_i(wlast), .wvalid_i(wvalid), .wready_i(wready),
        .err_cnt_o(errs), .run_cnt_o(runs)
    );

    function automatic logic [1:0] pick_stall(input logic en);
        return en ? 2'($urandom_range(3)) : 2'd0;
    endfunction

    // Read side of the memory answers AR then R
    always @(posedge clk) begin
        if (!rst_n) begin
            arready       <= 1'b0;
            rvalid        <= 1'b0;
            rdata         <= '0;
            rd_data_phase <= 1'b0;
            rd_wait       <= 2'd0;
        end else if (!rd_data_phase) begin
            arready <= arvalid && !arready && rd_wait == 2'd0;
            if (arvalid && !arready && rd_wait != 2'd0) rd_wait <= rd_wait - 2'd1;
            if (arvalid && arready) begin
                rdata         <= araddr ^ key;
                rd_data_phase <= 1'b1;
                rd_wait       <= pick_stall(stall_en);
            end
        end else begin
            rvalid <= rvalid ? !rready : rd_wait == 2'd0;
            if (!rvalid && rd_wait != 2'd0) rd_wait <= rd_wait - 2'd1;
            if (rvalid && rready) begin
                rd_data_phase <= 1'b0;
                rd_wait       <= pick_stall(stall_en);
            end
        end
    end

    // Write side answers AW then W then B
    always @(posedge clk) begin
        if (!rst_n) begin
            awready  <= 1'b0;
            wready   <= 1'b0;
            bvalid   <= 1'b0;
            wr_phase <= 2'd0;
            wr_wait  <= 2'd0;
        end else begin
            case (wr_phase)
                2'd0: begin
                    awready <= awvalid && !awready && wr_wait == 2'd0;
                    if (awvalid && !awready && wr_wait != 2'd0) wr_wait <= wr_wait - 2'd1;
                    if (awvalid && awready) begin
                        wr_phase <= 2'd1;
                        wr_wait  <= pick_stall(stall_en);
                    end
                end
                2'd1: begin
                    wready <= wvalid && !wready && wr_wait == 2'd0;
                    if (wvalid && !wready && wr_wait != 2'd0) wr_wait <= wr_wait - 2'd1;
                    if (wvalid && wready) begin
                        wr_phase <= 2'd2;
                        wr_wait  <= pick_stall(stall_en);
                    end
                end
                default: begin
                    bvalid <= bvalid ? !bready : wr_wait == 2'd0;
                    if (!bvalid && wr_wait != 2'd0) wr_wait <= wr_wait - 2'd1;
                    if (bvalid && bready) begin
                        wr_phase <= 2'd0;
                        wr_wait  <= pick_stall(stall_en);
                    end
                end
            endcase
        end
    end

    task automatic apply_row(input int r);
        int n;
        int limit;
        @(posedge clk);
        src_addr <= table_rows[r].src;
        dst_addr <= table_rows[r].dst;
        width    <= table_rows[r].width;
        key      <= table_rows[r].key;
        stall_en <= table_rows[r].stall;
        start    <= 1'b1;
        limit    = 64 * (int'(table_rows[r].width) + 2) * (int'(table_rows[r].width) + 2) + 1000;
        n = 0;
        do begin
            @(negedge clk);
            n++;
            if (n > start_limit) begin
                $display("Row %0d: done_o did not fall after start", r);
                hung = 1'b1;
            end
        end while (done && !hung);
        n = 0;
        do begin
            @(negedge clk);
            n++;
            if (n > limit) begin
                $display("Row %0d: done_o did not rise, the run never finished", r);
                hung = 1'b1;
            end
        end while (!done && !hung);
        repeat (3) @(posedge clk);   // Engine sits in finish while start is held
        start <= 1'b0;
        repeat (4) @(posedge clk);
    endtask

    initial begin
        void'($urandom(32'h7e20bbd8));
        rst_n    = 1'b0;
        start    = 1'b0;
        stall_en = 1'b0;
        src_addr = '0;
        dst_addr = '0;
        width    = '0;
        key      = '0;
        hung     = 1'b0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        repeat (3) @(posedge clk);
        for (int r = 0; r < n_rows && !hung; r++) begin
            apply_row(r);
        end
        @(negedge clk);
        $display("%0d of %0d runs checked, %0d errors, %0d timeouts", runs, n_rows, errs, hung);
        if (!hung && errs == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* verilog/block_sequencer.sv */
/*
 * Walks the padded output in 2x2 blocks, row-major, fetch then write.
 * Configuration is latched on start; width must be even and at least 4.
 */
`include "pad_dma_defines.svh"

module block_sequencer (
    input  logic                clk,
    input  logic                rst_n,
    input  pad_dma_pkg::addr_t  src_addr_i,
    input  pad_dma_pkg::addr_t  dst_addr_i,
    input  pad_dma_pkg::dim_t   mat_width_i,
    input  logic                start_i,
    input  logic                fetch_done_i,
    input  logic                write_done_i,
    output logic                done_o,
    output logic                fetch_start_o,
    output logic                write_start_o,
    output pad_dma_pkg::addr_t  src_base_o,
    output pad_dma_pkg::addr_t  dst_base_o,
    output pad_dma_pkg::dim_t   width_o,
    output pad_dma_pkg::dim_t   block_row_o,
    output pad_dma_pkg::dim_t   block_col_o,
    output pad_dma_pkg::ctr_t   center_row_o,
    output pad_dma_pkg::ctr_t   center_col_o
);
    pad_dma_pkg::seq_state_t        state;
    logic [`PAD_DMA_DIM_W:0]        bcol_step;   // One bit extra, block 62 + 2 overflows
    logic [`PAD_DMA_DIM_W:0]        brow_step;
    logic [`PAD_DMA_CTR_W:0]        ccol_step;
    logic [`PAD_DMA_CTR_W:0]        crow_step;
    logic [`PAD_DMA_CTR_W:0]        width_ext;
    pad_dma_pkg::ctr_t              width_ctr;

    assign bcol_step = {1'b0, block_col_o} + 2'd2;
    assign brow_step = {1'b0, block_row_o} + 2'd2;
    assign ccol_step = {1'b0, center_col_o} + 2'd2;
    assign crow_step = {1'b0, center_row_o} + 2'd2;
    assign width_ext = {2'b00, width_o};
    assign width_ctr = pad_dma_pkg::ctr_t'({1'b0, width_o});

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state         <= pad_dma_pkg::seq_idle;
            done_o        <= 1'b1;
            fetch_start_o <= 1'b0;
            write_start_o <= 1'b0;
        end else begin
            fetch_start_o <= 1'b0;
            write_start_o <= 1'b0;
            case (state)
                pad_dma_pkg::seq_idle: begin
                    if (start_i) begin
                        done_o        <= 1'b0;
                        fetch_start_o <= 1'b1;
                        state         <= pad_dma_pkg::seq_fetch;
                    end
                end
                pad_dma_pkg::seq_fetch: begin
                    if (fetch_done_i) begin
                        write_start_o <= 1'b1;
                        state         <= pad_dma_pkg::seq_write;
                    end
                end
                pad_dma_pkg::seq_write: begin
                    if (write_done_i) begin
                        // Last block column is col = width, padded output is width+2 wide
                        if (bcol_step <= {1'b0, width_o}) begin
                            fetch_start_o <= 1'b1;
                            state         <= pad_dma_pkg::seq_fetch;
                        end else if (brow_step > {1'b0, width_o}) begin
                            done_o <= 1'b1;
                            state  <= pad_dma_pkg::seq_finish;
                        end else begin
                            fetch_start_o <= 1'b1;
                            state         <= pad_dma_pkg::seq_fetch;
                        end
                    end
                end
                default: begin
                    if (!start_i) begin
                        state <= pad_dma_pkg::seq_idle;
                    end
                end
            endcase
        end
    end

    // Block and centre stepping, centres clamped to the last source row/column
    always_ff @(posedge clk) begin
        if (state == pad_dma_pkg::seq_idle && start_i) begin
            src_base_o   <= src_addr_i;
            dst_base_o   <= dst_addr_i;
            width_o      <= mat_width_i;
            block_row_o  <= '0;
            block_col_o  <= '0;
            center_row_o <= pad_dma_pkg::ctr_t'(1);
            center_col_o <= pad_dma_pkg::ctr_t'(1);
        end else if (state == pad_dma_pkg::seq_write && write_done_i) begin
            if (bcol_step <= {1'b0, width_o}) begin
                block_col_o  <= bcol_step[`PAD_DMA_DIM_W-1:0];
                center_col_o <= (ccol_step > width_ext) ? width_ctr
                                : pad_dma_pkg::ctr_t'(ccol_step[`PAD_DMA_CTR_W-1:0]);
            end else begin
                block_col_o  <= '0;
                center_col_o <= pad_dma_pkg::ctr_t'(1);
                block_row_o  <= brow_step[`PAD_DMA_DIM_W-1:0];
                center_row_o <= (crow_step > width_ext) ? width_ctr
                                : pad_dma_pkg::ctr_t'(crow_step[`PAD_DMA_CTR_W-1:0]);
            end
        end
    end

    // Mirror rule reads source index 2 and width-1, odd or tiny widths break it
    a_start_width: assert property (@(posedge clk) disable iff (!rst_n)
        (state == pad_dma_pkg::seq_idle && start_i)
        |-> (mat_width_i >= 4 && !mat_width_i[0]));

endmodule

/* verilog/pad_dma_top.sv */
/*
 * Mirror-padding DMA engine, single-beat 4-byte AXI reads and writes only.
 * Only one read or one write is ever outstanding on the bus.
 */
module pad_dma_top (
    input  logic                clk,
    input  logic                rst_n,
    input  pad_dma_pkg::addr_t  src_addr_i,
    input  pad_dma_pkg::addr_t  dst_addr_i,
    input  pad_dma_pkg::dim_t   mat_width_i,
    input  logic                start_i,
    output logic                done_o,
    output pad_dma_pkg::addr_t  araddr_o,
    output logic                arvalid_o,
    input  logic                arready_i,
    input  pad_dma_pkg::word_t  rdata_i,
    input  logic                rvalid_i,
    output logic                rready_o,
    output pad_dma_pkg::addr_t  awaddr_o,
    output logic                awvalid_o,
    input  logic                awready_i,
    output pad_dma_pkg::word_t  wdata_o,
    output logic                wlast_o,
    output logic                wvalid_o,
    input  logic                wready_i,
    input  logic                bvalid_i,
    output logic                bready_o
);
    logic                   fetch_start;
    logic                   fetch_done;
    logic                   write_start;
    logic                   write_done;
    pad_dma_pkg::addr_t     src_base;
    pad_dma_pkg::addr_t     dst_base;
    pad_dma_pkg::dim_t      width;
    pad_dma_pkg::dim_t      block_row;
    pad_dma_pkg::dim_t      block_col;
    pad_dma_pkg::ctr_t      center_row;
    pad_dma_pkg::ctr_t      center_col;
    pad_dma_pkg::window_t   window;

    block_sequencer u_seq (
        .clk(clk), .rst_n(rst_n),
        .src_addr_i(src_addr_i), .dst_addr_i(dst_addr_i),
        .mat_width_i(mat_width_i), .start_i(start_i),
        .fetch_done_i(fetch_done), .write_done_i(write_done),
        .done_o(done_o),
        .fetch_start_o(fetch_start), .write_start_o(write_start),
        .src_base_o(src_base), .dst_base_o(dst_base), .width_o(width),
        .block_row_o(block_row), .block_col_o(block_col),
        .center_row_o(center_row), .center_col_o(center_col)
    );

    window_fetch u_fetch (
        .clk(clk), .rst_n(rst_n),
        .fetch_start_i(fetch_start), .src_base_i(src_base), .width_i(width),
        .center_row_i(center_row), .center_col_i(center_col),
        .arready_i(arready_i), .rdata_i(rdata_i), .rvalid_i(rvalid_i),
        .araddr_o(araddr_o), .arvalid_o(arvalid_o), .rready_o(rready_o),
        .window_o(window), .fetch_done_o(fetch_done)
    );

    block_writer u_writer (
        .clk(clk), .rst_n(rst_n),
        .write_start_i(write_start), .dst_base_i(dst_base), .width_i(width),
        .block_row_i(block_row), .block_col_i(block_col),
        .center_row_i(center_row), .center_col_i(center_col),
        .window_i(window),
        .awready_i(awready_i), .wready_i(wready_i), .bvalid_i(bvalid_i),
        .awaddr_o(awaddr_o), .awvalid_o(awvalid_o),
        .wdata_o(wdata_o), .wlast_o(wlast_o), .wvalid_o(wvalid_o),
        .bready_o(bready_o), .write_done_o(write_done)
    );

endmodule

/* window_fetch/window_fetch.sv */
/*
 * Reads the 3x3 source window around a centre with one single-beat read at a time.
 * Coordinates outside the source are clamped to 1..width before addressing.
 */
`include "pad_dma_defines.svh"

module window_fetch (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    fetch_start_i,
    input  pad_dma_pkg::addr_t      src_base_i,
    input  pad_dma_pkg::dim_t       width_i,
    input  pad_dma_pkg::ctr_t       center_row_i,
    input  pad_dma_pkg::ctr_t       center_col_i,
    input  logic                    arready_i,
    input  pad_dma_pkg::word_t      rdata_i,
    input  logic                    rvalid_i,
    output pad_dma_pkg::addr_t      araddr_o,
    output logic                    arvalid_o,
    output logic                    rready_o,
    output pad_dma_pkg::window_t    window_o,
    output logic                    fetch_done_o
);
    localparam logic [3:0] last_word = 4'(`PAD_DMA_WIN_N - 1);

    logic [3:0]         cnt;       // Word in flight
    logic [3:0]         idx;       // Word whose address gets loaded
    logic [3:0]         col_rem;
    logic [1:0]         off_r;
    logic [1:0]         off_c;
    pad_dma_pkg::ctr_t  tgt_r;
    pad_dma_pkg::ctr_t  tgt_c;
    pad_dma_pkg::ctr_t  cl_r;
    pad_dma_pkg::ctr_t  cl_c;
    pad_dma_pkg::ctr_t  width_s;
    pad_dma_pkg::dim_t  row_z;
    pad_dma_pkg::dim_t  col_z;
    pad_dma_pkg::addr_t ar_next;
    logic               ar_hs;
    logic               r_hs;
    logic               fetch_busy;   // Between a start and its done pulse

    assign ar_hs = arvalid_o & arready_i;
    assign r_hs  = rvalid_i & rready_o;
    assign idx   = fetch_start_i ? 4'd0 : cnt + 4'd1;

    // Row and column offset inside the window
    assign off_r   = (idx >= 4'd6) ? 2'd2 : (idx >= 4'd3) ? 2'd1 : 2'd0;
    assign col_rem = idx - 4'd3 * {2'b00, off_r};
    assign off_c   = col_rem[1:0];

    assign width_s = pad_dma_pkg::ctr_t'({1'b0, width_i});
    assign tgt_r   = center_row_i - pad_dma_pkg::ctr_t'(1) + pad_dma_pkg::ctr_t'(off_r);
    assign tgt_c   = center_col_i - pad_dma_pkg::ctr_t'(1) + pad_dma_pkg::ctr_t'(off_c);

    always_comb begin
        cl_r = tgt_r;
        cl_c = tgt_c;
        if (tgt_r < pad_dma_pkg::ctr_t'(1)) cl_r = pad_dma_pkg::ctr_t'(1);
        else if (tgt_r > width_s) cl_r = width_s;
        if (tgt_c < pad_dma_pkg::ctr_t'(1)) cl_c = pad_dma_pkg::ctr_t'(1);
        else if (tgt_c > width_s) cl_c = width_s;
    end

    assign row_z   = cl_r[`PAD_DMA_DIM_W-1:0] - 1'b1;   // 0-based
    assign col_z   = cl_c[`PAD_DMA_DIM_W-1:0] - 1'b1;
    assign ar_next = src_base_i + ((pad_dma_pkg::addr_t'(row_z) * pad_dma_pkg::addr_t'(width_i)
                     + pad_dma_pkg::addr_t'(col_z)) << 2);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cnt          <= '0;
            arvalid_o    <= 1'b0;
            rready_o     <= 1'b0;
            fetch_done_o <= 1'b0;
        end else begin
            fetch_done_o <= 1'b0;
            if (fetch_start_i) begin
                cnt       <= '0;
                arvalid_o <= 1'b1;
                rready_o  <= 1'b1;   // Held for the whole window
            end else begin
                if (ar_hs) begin
                    arvalid_o <= 1'b0;
                end
                if (r_hs) begin
                    if (cnt == last_word) begin
                        rready_o     <= 1'b0;
                        fetch_done_o <= 1'b1;
                    end else begin
                        cnt       <= cnt + 4'd1;
                        arvalid_o <= 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_start_i || (r_hs && cnt != last_word)) begin
            araddr_o <= ar_next;
        end
        if (r_hs) begin
            window_o[cnt*`PAD_DMA_DATA_W +: `PAD_DMA_DATA_W] <= rdata_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fetch_busy <= 1'b0;
        end else if (fetch_start_i) begin
            fetch_busy <= 1'b1;
        end else if (fetch_done_o) begin
            fetch_busy <= 1'b0;
        end
    end

    a_ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (arvalid_o && !arready_i) |=> (arvalid_o && $stable(araddr_o)));

    // Each done pulse closes exactly one started window
    a_done_after_start: assert property (@(posedge clk) disable iff (!rst_n)
        fetch_done_o |-> fetch_busy);

endmodule
